/* list.f */
logic/synth_pkg.sv
logic/midi_decoder.sv
logic/sample_timer.sv
logic/pulse_gen.sv
logic/sigma_delta_dac.sv
logic/synth_top.sv
dv/synth_assertions.sv
dv/synth_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the synthesizer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module synth_tb -f list.f -o synth_sim &&
    ./obj_dir/synth_sim 2>&1 | tee /dev/stderr | grep -qF '*** PASSED ***' &&
    echo "simulation run ok" && exit 0 ||
    { echo "simulation run not ok"; exit 1; }

/* dv/synth_tb.sv */
module synth_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import synth_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 16;
    // Sample periods of listening after each message
    localparam int HOLD            = 32;
    localparam int N_RANDOM        = 12;
    localparam int N_SENDS         = 13 + N_RANDOM;
    localparam int DAC_WINDOW      = 1024;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 4 * SAMPLE_PERIOD
        + N_SENDS * (HOLD + 3) * SAMPLE_PERIOD + DAC_WINDOW + 1000;

    logic       clk;
    logic       reset;
    logic       byte_valid;
    midi_byte_t byte_data;
    sample_t    left_sample;
    sample_t    right_sample;
    logic       left_valid;
    logic       right_valid;
    logic       dac_left;
    logic       dac_right;

    // Model voices with index 0 left and 1 right
    bit      m_active [2] = '{1'b0, 1'b0};
    int      m_note   [2] = '{0, 0};
    int      m_amp    [2] = '{0, 0};
    bit      m_pos    [2] = '{1'b1, 1'b1};
    int      m_step   [2] = '{0, 0};

    sample_t exp_left;
    sample_t exp_right;
    int      n_pulses;
    int      seed = 32'h9f8b;
    int      r;

    synth_top synth_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    // Expected sample of one voice on its strobe before the phase advance
    function automatic sample_t next_sample(input int v);
        int s;
        if (!m_active[v]) return '0;
        s = m_pos[v] ? m_amp[v] : -m_amp[v];
        m_step[v]++;
        if (m_step[v] == 128 - m_note[v]) begin
            m_pos[v]  = !m_pos[v];
            m_step[v] = 0;
        end
        return sample_t'(s);
    endfunction

    // Note-on or note-off as the voice sees it
    function automatic void apply_note(input midi_byte_t status, input midi_data_t note,
                                       input midi_data_t vel);
        int v;
        if (status[3:0] == LEFT_CHAN) v = 0;
        else if (status[3:0] == RIGHT_CHAN) v = 1;
        else return;
        if (status[6:4] == CMD_NOTE_ON && vel != '0) begin
            m_active[v] = 1'b1;
            m_note[v]   = int'(note);
            m_amp[v]    = int'(vel) * (1 << AMP_SHIFT);
            m_pos[v]    = 1'b1;
            m_step[v]   = 0;
        end else if ((status[6:4] == CMD_NOTE_ON || status[6:4] == CMD_NOTE_OFF)
                     && m_note[v] == int'(note)) begin
            m_active[v] = 1'b0;
        end
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    task automatic wait_periods(input int k);
        repeat (k) begin
            @(negedge clk);
            while (!right_valid) @(negedge clk);
        end
    endtask

    // Bytes go out right after a right_valid pulse
    task automatic send_msg(input int n, input midi_byte_t b0, input midi_byte_t b1,
                            input midi_byte_t b2, input midi_byte_t b3);
        midi_byte_t bytes [4];
        bytes = '{b0, b1, b2, b3};
        wait_periods(1);
        @(posedge clk);
        #10;
        for (int i = 0; i < n; i++) begin
            byte_valid = 1'b1;
            byte_data  = bytes[i];
            @(posedge clk);
            #10;
        end
        byte_valid = 1'b0;
        byte_data  = '0;
    endtask

    task automatic note_msg(input midi_byte_t status, input midi_data_t note,
                            input midi_data_t vel);
        send_msg(3, status, {1'b0, note}, {1'b0, vel}, 8'h00);
        apply_note(status, note, vel);
        wait_periods(HOLD);
    endtask

    // Ones of each DAC against the offset samples over one window
    task automatic check_dac();
        longint sum_l;
        longint sum_r;
        longint ones_l;
        longint ones_r;
        sum_l  = 0;
        sum_r  = 0;
        ones_l = 0;
        ones_r = 0;
        repeat (DAC_WINDOW) begin
            @(negedge clk);
            sum_l  += longint'(left_sample) + (1 << (SAMPLE_W - 1));
            sum_r  += longint'(right_sample) + (1 << (SAMPLE_W - 1));
            ones_l += longint'(dac_left);
            ones_r += longint'(dac_right);
        end
        sum_l = sum_l >> SAMPLE_W;
        sum_r = sum_r >> SAMPLE_W;
        assert (ones_l <= sum_l + 2 && ones_l + 2 >= sum_l)
            else fail_run($sformatf("** Error dac_left ones expected %h actual %h",
                                    sum_l, ones_l));
        assert (ones_r <= sum_r + 2 && ones_r + 2 >= sum_r)
            else fail_run($sformatf("** Error dac_right ones expected %h actual %h",
                                    sum_r, ones_r));
    endtask

    // ------------------------------------------------------------------------
    // Comparison on every valid pulse
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (!reset && left_valid) begin
            exp_left = next_sample(0);
            assert (left_sample == exp_left)
                else fail_run($sformatf("** Error left_sample expected %h actual %h",
                                        exp_left, left_sample));
        end
        if (!reset && right_valid) begin
            exp_right = next_sample(1);
            assert (right_sample == exp_right)
                else fail_run($sformatf("** Error right_sample expected %h actual %h",
                                        exp_right, right_sample));
        end
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        byte_valid = 1'b0;
        byte_data  = '0;
        reset      = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        reset = 1'b0;

        // Idle after reset gives zero samples at the strobe rate
        @(negedge clk);
        assert (left_sample == '0 && right_sample == '0)
            else fail_run($sformatf("** Error left_sample %h right_sample %h expected 0",
                                    left_sample, right_sample));
        n_pulses = 0;
        repeat (4 * SAMPLE_PERIOD) begin
            @(negedge clk);
            if (left_valid) n_pulses++;
        end
        assert (n_pulses == 4)
            else fail_run($sformatf("** Error left_valid pulses expected %h actual %h",
                                    4, n_pulses));
        // Stray data before any status byte
        send_msg(2, 8'h45, 8'h33, 8'h00, 8'h00);
        wait_periods(HOLD);

        // One voice per channel
        note_msg(8'h90, 7'd100, 7'd64);
        note_msg(8'h91, 7'd110, 7'd127);
        // Wrong note keeps playing before matching off and zero velocity
        note_msg(8'h80, 7'd99, 7'd0);
        note_msg(8'h80, 7'd100, 7'd0);
        note_msg(8'h91, 7'd110, 7'd0);

        // Running status pair
        note_msg(8'h90, 7'd60, 7'd20);
        send_msg(2, 8'd62, 8'd30, 8'h00, 8'h00);
        apply_note(8'h90, 7'd62, 7'd30);
        wait_periods(HOLD);
        // Clock byte in the middle of a message
        send_msg(4, 8'h90, 8'd64, 8'hF8, 8'd40);
        apply_note(8'h90, 7'd64, 7'd40);
        wait_periods(HOLD);
        // Channel 2 and program change leave the voices alone
        note_msg(8'h92, 7'd70, 7'd100);
        send_msg(2, 8'hC0, 8'd5, 8'h00, 8'h00);
        wait_periods(HOLD);

        // Random note-on and note-off on both channels
        for (int i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            note_msg({3'b100, r[20], 3'b000, r[16]}, r[6:0], r[14:8]);
        end

        // Held notes for the DAC window
        note_msg(8'h90, 7'd90, 7'd100);
        note_msg(8'h91, 7'd70, 7'd50);
        check_dac();

        $display("*** PASSED ***");
        $finish;
    end

    // Watchdog sized from the message count and the DAC window
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("timeout, the test sequence did not finish in time");
    end

endmodule

/* dv/synth_assertions.sv */
module synth_assertions (
    input logic clk,
    input logic reset,
    input logic left_valid,
    input logic right_valid
);
    timeunit 1ns;
    timeprecision 1ps;
    import synth_pkg::*;

    // ------------------------------------------------------------------------
    // Sample strobes
    // ------------------------------------------------------------------------
    // Left and right phases never overlap
    a_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(left_valid && right_valid))
        else $error("left_valid and right_valid high in the same cycle");

    // Single cycle pulses
    a_left_width: assert property (@(posedge clk) disable iff (reset)
        left_valid |=> !left_valid)
        else $error("left_valid longer than one cycle");
    a_right_width: assert property (@(posedge clk) disable iff (reset)
        right_valid |=> !right_valid)
        else $error("right_valid longer than one cycle");

    // One pulse per sample period
    a_left_period: assert property (@(posedge clk) disable iff (reset)
        left_valid |-> ##SAMPLE_PERIOD left_valid)
        else $error("left_valid did not recur after one sample period");
    a_right_period: assert property (@(posedge clk) disable iff (reset)
        right_valid |-> ##SAMPLE_PERIOD right_valid)
        else $error("right_valid did not recur after one sample period");

endmodule

bind synth_top synth_assertions synth_assertions_i (
    .clk         (clk),
    .reset       (reset),
    .left_valid  (left_valid),
    .right_valid (right_valid)
);

/* logic/synth_top.sv */
module synth_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  byte_valid,
    input  synth_pkg::midi_byte_t byte_data,
    output synth_pkg::sample_t    left_sample,
    output synth_pkg::sample_t    right_sample,
    output logic                  left_valid,
    output logic                  right_valid,
    output logic                  dac_left,
    output logic                  dac_right
);
    import synth_pkg::*;

    // Decoded message
    logic       midi_rdy;
    midi_cmd_t  midi_cmd;
    midi_chan_t midi_chan;
    midi_data_t midi_data0;
    midi_data_t midi_data1;

    // Sample phase strobes
    logic       gen_left_sample;
    logic       gen_right_sample;

    // ------------------------------------------------------------------------
    // MIDI byte stream to messages
    // ------------------------------------------------------------------------
    midi_decoder midi_decoder_i (
        .clk        (clk),
        .reset      (reset),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .midi_rdy   (midi_rdy),
        .midi_cmd   (midi_cmd),
        .midi_chan  (midi_chan),
        .midi_data0 (midi_data0),
        .midi_data1 (midi_data1)
    );

    sample_timer sample_timer_i (
        .clk              (clk),
        .reset            (reset),
        .gen_left_sample  (gen_left_sample),
        .gen_right_sample (gen_right_sample)
    );

    // Two voices
    pulse_gen pulse_gen_i (
        .clk              (clk),
        .reset            (reset),
        .gen_left_sample  (gen_left_sample),
        .gen_right_sample (gen_right_sample),
        .midi_rdy         (midi_rdy),
        .midi_cmd         (midi_cmd),
        .midi_chan        (midi_chan),
        .midi_data0       (midi_data0),
        .midi_data1       (midi_data1),
        .left_sample      (left_sample),
        .right_sample     (right_sample),
        .left_valid       (left_valid),
        .right_valid      (right_valid)
    );

    // ------------------------------------------------------------------------
    // One bit DACs
    // ------------------------------------------------------------------------
    sigma_delta_dac left_dac_i (
        .clk   (clk),
        .reset (reset),
        .din   (left_sample),
        .dout  (dac_left)
    );

    sigma_delta_dac right_dac_i (
        .clk   (clk),
        .reset (reset),
        .din   (right_sample),
        .dout  (dac_right)
    );

endmodule

/* logic/sigma_delta_dac.sv */
module sigma_delta_dac (
    input  logic               clk,
    input  logic               reset,
    input  synth_pkg::sample_t din,
    output logic               dout
);
    import synth_pkg::*;

    // Offset binary, mid scale for a zero sample
    logic [SAMPLE_W-1:0] din_offset;
    logic [SAMPLE_W-1:0] acc;
    // One extra bit for the carry
    logic [SAMPLE_W:0]   sum;

    // Flip the sign bit to go from two's complement to unsigned
    assign din_offset = {~din[SAMPLE_W-1], din[SAMPLE_W-2:0]};
    assign sum        = {1'b0, acc} + {1'b0, din_offset};

    // ------------------------------------------------------------------------
    // First order modulator
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            acc  <= '0;
            dout <= 1'b0;
        end else begin
            // Remainder stays in the accumulator
            acc  <= sum[SAMPLE_W-1:0];
            // Carry out is the density bit
            dout <= sum[SAMPLE_W];
        end
    end

endmodule

/* logic/pulse_gen.sv */
module pulse_gen (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  gen_left_sample,
    input  logic                  gen_right_sample,
    input  logic                  midi_rdy,
    input  synth_pkg::midi_cmd_t  midi_cmd,
    input  synth_pkg::midi_chan_t midi_chan,
    input  synth_pkg::midi_data_t midi_data0,
    input  synth_pkg::midi_data_t midi_data1,
    output synth_pkg::sample_t    left_sample,
    output synth_pkg::sample_t    right_sample,
    output logic                  left_valid,
    output logic                  right_valid
);
    import synth_pkg::*;

    // Voice state, index 0 is left, 1 is right
    logic       active   [NUM_VOICES];
    midi_data_t note     [NUM_VOICES];
    sample_t    amp      [NUM_VOICES];
    // High while the wave sits at +amp
    logic       pol_pos  [NUM_VOICES];
    step_t      step     [NUM_VOICES];

    // Per voice strobe and message select
    logic       strobe   [NUM_VOICES];
    logic       hit      [NUM_VOICES];

    step_t      half     [NUM_VOICES];
    step_t      step_inc [NUM_VOICES];
    sample_t    wave     [NUM_VOICES];

    // Output registers
    sample_t    sample_q [NUM_VOICES];
    logic       valid_q  [NUM_VOICES];

    logic       note_on;
    logic       note_off;

    assign strobe[0] = gen_left_sample;
    assign strobe[1] = gen_right_sample;

    // Only place the channel is looked at
    assign hit[0] = midi_rdy && (midi_chan == LEFT_CHAN);
    assign hit[1] = midi_rdy && (midi_chan == RIGHT_CHAN);

    // Velocity 0 note-on counts as note-off
    assign note_on  = (midi_cmd == CMD_NOTE_ON) && (midi_data1 != '0);
    assign note_off = (midi_cmd == CMD_NOTE_OFF) ||
                      ((midi_cmd == CMD_NOTE_ON) && (midi_data1 == '0));

    // ------------------------------------------------------------------------
    // Square wave value and phase step
    // ------------------------------------------------------------------------
    always_comb begin
        for (int v = 0; v < NUM_VOICES; v++) begin
            // Higher note, shorter half period
            half[v]     = step_t'(HALF_BASE) - step_t'(note[v]);
            step_inc[v] = step[v] + 1'b1;
            if (!active[v]) begin
                wave[v] = '0;
            end else if (pol_pos[v]) begin
                wave[v] = amp[v];
            end else begin
                wave[v] = -amp[v];
            end
        end
    end

    // ------------------------------------------------------------------------
    // Voice control
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                active[v]  <= 1'b0;
                pol_pos[v] <= 1'b1;
                step[v]    <= '0;
            end
        end else begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                // Advance phase after emitting the current sample
                if (strobe[v] && active[v]) begin
                    if (step_inc[v] == half[v]) begin
                        pol_pos[v] <= !pol_pos[v];
                        step[v]    <= '0;
                    end else begin
                        step[v] <= step_inc[v];
                    end
                end
                // A message on the same edge overrides the phase update
                if (hit[v] && note_on) begin
                    active[v]  <= 1'b1;
                    pol_pos[v] <= 1'b1;
                    step[v]    <= '0;
                end else if (hit[v] && note_off && active[v] && midi_data0 == note[v]) begin
                    active[v] <= 1'b0;
                end
            end
        end
    end

    // Note and amplitude, meaningful only while active
    always_ff @(posedge clk) begin
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (hit[v] && note_on) begin
                note[v] <= midi_data0;
                amp[v]  <= sample_t'(midi_data1) << AMP_SHIFT;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Sample output, one cycle after the strobe
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                sample_q[v] <= '0;
                valid_q[v]  <= 1'b0;
            end
        end else begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                valid_q[v] <= strobe[v];
                if (strobe[v]) begin
                    sample_q[v] <= wave[v];
                end
            end
        end
    end

    assign left_sample  = sample_q[0];
    assign right_sample = sample_q[1];
    assign left_valid   = valid_q[0];
    assign right_valid  = valid_q[1];

endmodule

/* logic/sample_timer.sv */
module sample_timer (
    input  logic clk,
    input  logic reset,
    output logic gen_left_sample,
    output logic gen_right_sample
);
    import synth_pkg::*;

    // Position inside the sample period
    sample_cnt_t count;

    // ------------------------------------------------------------------------
    // Modulo SAMPLE_PERIOD counter
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (count == sample_cnt_t'(SAMPLE_PERIOD - 1)) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Left on phase 0, right half a period later
    assign gen_left_sample  = count == '0;
    assign gen_right_sample = count == sample_cnt_t'(RIGHT_OFFSET);

endmodule

/* logic/midi_decoder.sv */
module midi_decoder (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  byte_valid,
    input  synth_pkg::midi_byte_t byte_data,
    output logic                  midi_rdy,
    output synth_pkg::midi_cmd_t  midi_cmd,
    output synth_pkg::midi_chan_t midi_chan,
    output synth_pkg::midi_data_t midi_data0,
    output synth_pkg::midi_data_t midi_data1
);
    import synth_pkg::*;

    // WAIT_STATUS only after reset, running status keeps us in the data states
    typedef enum logic [1:0] {
        WAIT_STATUS,
        WAIT_DATA0,
        WAIT_DATA1
    } state_t;

    state_t     state;

    // Running status
    midi_cmd_t  status_cmd;
    midi_chan_t status_chan;
    // First data byte of a two byte message
    midi_data_t data0_q;

    logic is_system;
    logic is_status;
    logic is_data;
    logic one_byte_cmd;

    // ------------------------------------------------------------------------
    // Byte classification
    // ------------------------------------------------------------------------
    // 0xF0..0xFF, realtime and common system bytes
    assign is_system    = byte_data[7:4] == 4'hF;
    // Channel status 0x80..0xEF
    assign is_status    = byte_valid && byte_data[7] && !is_system;
    assign is_data      = byte_valid && !byte_data[7];
    // Program change and channel pressure carry one data byte
    assign one_byte_cmd = (status_cmd == CMD_PROG_CHANGE) ||
                          (status_cmd == CMD_CHAN_PRESSURE);

    // ------------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= WAIT_STATUS;
            midi_rdy <= 1'b0;
        end else begin
            midi_rdy <= 1'b0;
            if (is_status) begin
                // New status restarts the message
                state <= WAIT_DATA0;
            end else if (is_data) begin
                case (state)
                    WAIT_STATUS: begin
                        // Stray data, no status yet
                        state <= WAIT_STATUS;
                    end
                    WAIT_DATA0: begin
                        if (one_byte_cmd) begin
                            midi_rdy <= 1'b1;
                        end else begin
                            state <= WAIT_DATA1;
                        end
                    end
                    WAIT_DATA1: begin
                        midi_rdy <= 1'b1;
                        // Stay ready for running status
                        state    <= WAIT_DATA0;
                    end
                    default: begin
                        state <= WAIT_STATUS;
                    end
                endcase
            end
            // System bytes fall through, state untouched
        end
    end

    // ------------------------------------------------------------------------
    // Message payload
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (is_status) begin
            status_cmd  <= byte_data[6:4];
            status_chan <= byte_data[3:0];
        end
        if (is_data && state == WAIT_DATA0) begin
            data0_q <= byte_data[6:0];
            if (one_byte_cmd) begin
                midi_cmd   <= status_cmd;
                midi_chan  <= status_chan;
                midi_data0 <= byte_data[6:0];
                midi_data1 <= '0;
            end
        end
        // Output fields frozen apart from status regs while rdy is high
        if (is_data && state == WAIT_DATA1) begin
            midi_cmd   <= status_cmd;
            midi_chan  <= status_chan;
            midi_data0 <= data0_q;
            midi_data1 <= byte_data[6:0];
        end
    end

endmodule

/* logic/synth_pkg.sv */
package synth_pkg;

    // ------------------------------------------------------------------------
    // MIDI field widths
    // ------------------------------------------------------------------------
    localparam int MIDI_BYTE_W = 8;
    localparam int MIDI_DATA_W = 7;
    localparam int MIDI_CHAN_W = 4;
    localparam int MIDI_CMD_W  = 3;

    typedef logic [MIDI_BYTE_W-1:0] midi_byte_t;
    typedef logic [MIDI_DATA_W-1:0] midi_data_t;
    typedef logic [MIDI_CHAN_W-1:0] midi_chan_t;
    // Bits 6..4 of the status byte
    typedef logic [MIDI_CMD_W-1:0]  midi_cmd_t;

    // Channel commands we care about
    localparam midi_cmd_t CMD_NOTE_OFF      = 3'd0;
    localparam midi_cmd_t CMD_NOTE_ON       = 3'd1;
    // Commands carrying a single data byte
    localparam midi_cmd_t CMD_PROG_CHANGE   = 3'd4;
    localparam midi_cmd_t CMD_CHAN_PRESSURE = 3'd5;

    // Voice to channel mapping
    localparam midi_chan_t LEFT_CHAN  = 4'd0;
    localparam midi_chan_t RIGHT_CHAN = 4'd1;
    localparam int         NUM_VOICES = 2;

    // ------------------------------------------------------------------------
    // Audio path
    // ------------------------------------------------------------------------
    localparam int SAMPLE_W = 18;
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Clocks per sample and phase of the right strobe
    localparam int SAMPLE_PERIOD = 32;
    localparam int RIGHT_OFFSET  = 16;
    localparam int SAMPLE_CNT_W  = $clog2(SAMPLE_PERIOD);
    typedef logic [SAMPLE_CNT_W-1:0] sample_cnt_t;

    // Velocity to amplitude, 127 << 10 still positive in sample_t
    localparam int AMP_SHIFT = 10;

    // Half period in samples is HALF_BASE minus the note, up to 128
    localparam int HALF_BASE = 1 << MIDI_DATA_W;
    typedef logic [MIDI_DATA_W:0] step_t;

endpackage
